/* project.f */
rtl/mem_pkg.sv
rtl/pipe_reg.sv
rtl/dmem.sv
rtl/flow_ctrl.sv
rtl/mem_stage.sv
rtl/mem_subsys_top.sv
verif/tb_clkgen.sv
verif/tb_mem_subsys.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with verilator, run it, check the log
set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_mem_subsys
OBJ_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module "$TOP" \
    -Mdir "$OBJ_DIR" -f project.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed"
    exit 1
fi

"./$OBJ_DIR/V$TOP" > "$SIM_LOG" 2>&1
run_status=$?
cat "$SIM_LOG"

if grep -q "SOME TESTS FAILED" "$SIM_LOG"; then
    echo "simulation failed"
    exit 1
fi
if [ "$run_status" -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi
echo "simulation passed"
exit 0

/* verif/tb_mem_subsys.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mem_subsys;
    import mem_pkg::*;

    localparam int          RESET_TIMEOUT  = 20;
    localparam int          ACCEPT_TIMEOUT = 200;
    localparam int          DRAIN_TIMEOUT  = 400;
    localparam int          N_RANDOM       = 300;
    localparam logic [31:0] SEED           = 32'h653;

    typedef struct packed {
        logic [XLEN-1:0]   data;
        logic [REG_AW-1:0] waddr;
        logic              we;
        int                acc_edge;
        logic              lat_check; // exact latency expected for an alu op
    } expect_t;

    logic              clk;
    logic              rst_n;
    logic              ex_valid;
    logic [XLEN-1:0]   ex_op_c;
    logic [XLEN-1:0]   ex_store_data;
    logic [REG_AW-1:0] ex_reg_waddr;
    logic              ex_reg_we;
    logic              ex_mtype;
    logic              ex_mem_rw;
    logic [1:0]        ex_mem_width;
    logic              ext_stall;
    logic              flush;
    logic              stall;
    logic              wb_valid;
    logic [XLEN-1:0]   wb_data;
    logic [REG_AW-1:0] wb_reg_waddr;
    logic              wb_reg_we;

    expect_t           exp_q [$];
    logic [XLEN-1:0]   mirror [DMEM_DEPTH];
    logic [31:0]       lfsr_q;
    int                edge_cnt      = 0;
    int                fail_cnt      = 0;
    logic              memwb_loaded  = 1'b0; // mem/wb took a new entry on the last edge
    logic              check_alu_lat = 1'b0;
    logic              stall_rand    = 1'b0;
    string             test_name     = "reset";

    tb_clkgen u_clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mem_subsys_top DUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .ex_valid_i      (ex_valid),
        .ex_op_c_i       (ex_op_c),
        .ex_store_data_i (ex_store_data),
        .ex_reg_waddr_i  (ex_reg_waddr),
        .ex_reg_we_i     (ex_reg_we),
        .ex_mtype_i      (ex_mtype),
        .ex_mem_rw_i     (ex_mem_rw),
        .ex_mem_width_i  (ex_mem_width),
        .ext_stall_i     (ext_stall),
        .flush_i         (flush),
        .stall_o         (stall),
        .wb_valid_o      (wb_valid),
        .wb_data_o       (wb_data),
        .wb_reg_waddr_o  (wb_reg_waddr),
        .wb_reg_we_o     (wb_reg_we)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // mirror indexed by addr[9:2] with byte and half in the low lanes
    function automatic void ref_result(input logic mtype, input logic rw,
            input logic [1:0] width, input logic [XLEN-1:0] op_c,
            input logic [XLEN-1:0] sdata, input logic [REG_AW-1:0] waddr, input logic we);
        expect_t         e;
        logic [7:0]      idx;
        logic [XLEN-1:0] word;
        idx    = op_c[9:2];
        word   = mirror[idx];
        e.data = op_c; // alu value or the address of a store
        if (mtype && rw) begin
            case (width)
                WIDTH_BYTE: word[7:0] = sdata[7:0];
                WIDTH_HALF: word[15:0] = sdata[15:0];
                WIDTH_WORD: word = sdata;
                default: ;
            endcase
            mirror[idx] = word;
        end else if (mtype) begin
            case (width)
                WIDTH_BYTE: e.data = {{24{word[7]}}, word[7:0]};
                WIDTH_HALF: e.data = {{16{word[15]}}, word[15:0]};
                WIDTH_WORD: e.data = word;
                default:    e.data = '0;
            endcase
        end
        e.waddr     = waddr;
        e.we        = we;
        e.acc_edge  = edge_cnt;
        e.lat_check = check_alu_lat && !mtype;
        exp_q.push_back(e);
    endfunction

    task automatic abort_run(input string msg);
        $display("ERROR in %s: %s", test_name, msg);
        $display("SOME TESTS FAILED");
        fail_cnt++;
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] exp_v,
            input logic [31:0] act_v);
        $display("FAILED %s %s: expected %h actual %h", test_name, what, exp_v, act_v);
        $display("SOME TESTS FAILED");
        fail_cnt++;
        $fatal(1, "value mismatch");
    endtask

    task automatic check_wb();
        expect_t e;
        assert (exp_q.size() != 0) else abort_run("wb output with no instruction outstanding");
        if (exp_q.size() != 0) begin
            e = exp_q.pop_front();
            assert (wb_data == e.data) else report_mismatch("wb_data", e.data, wb_data);
            assert (wb_reg_waddr == e.waddr)
                else report_mismatch("wb_reg_waddr", 32'(e.waddr), 32'(wb_reg_waddr));
            assert (wb_reg_we == e.we)
                else report_mismatch("wb_reg_we", 32'(e.we), 32'(wb_reg_we));
            if (e.lat_check) begin
                assert (edge_cnt - e.acc_edge == 2)
                    else report_mismatch("alu latency", 32'd2, 32'(edge_cnt - e.acc_edge));
            end
        end
    endtask

    // sees the values from before each edge
    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                mirror[i] = '0;
            end
            exp_q.delete();
        end else begin
            assert (wb_valid || !wb_reg_we)
                else report_mismatch("wb_reg_we on a bubble", 32'd0, 32'(wb_reg_we));
            if (wb_valid && memwb_loaded) begin
                check_wb();
            end
            if (flush) begin
                // the flushed op is the newest one still in ex/mem
                assert (exp_q.size() != 0) else abort_run("flush with ex/mem empty");
                if (exp_q.size() != 0) begin
                    void'(exp_q.pop_back());
                end
            end else if (ex_valid && !stall) begin
                ref_result(ex_mtype, ex_mem_rw, ex_mem_width, ex_op_c, ex_store_data,
                           ex_reg_waddr, ex_reg_we);
            end
            memwb_loaded <= !ext_stall;
        end
        edge_cnt <= edge_cnt + 1;
    end

    task automatic tick();
        @(posedge clk);
        if (stall_rand) begin
            ext_stall <= (rand_bits(2) == 32'd3); // about one cycle in four
        end
    endtask

    task automatic issue_op(input logic mtype, input logic rw, input logic [1:0] width,
            input logic [XLEN-1:0] op_c, input logic [XLEN-1:0] sdata,
            input logic [REG_AW-1:0] waddr, input logic we);
        int waited;
        waited = 0;
        ex_valid      <= 1'b1;
        ex_mtype      <= mtype;
        ex_mem_rw     <= rw;
        ex_mem_width  <= width;
        ex_op_c       <= op_c;
        ex_store_data <= sdata;
        ex_reg_waddr  <= waddr;
        ex_reg_we     <= we;
        do begin
            tick();
            waited++;
            assert (waited < ACCEPT_TIMEOUT) else abort_run("instruction never accepted");
        end while (stall);
        ex_valid <= 1'b0;
    endtask

    task automatic issue_random(input logic allow_mem);
        logic [1:0]        kind;
        logic [1:0]        width;
        logic [XLEN-1:0]   op_c;
        logic [XLEN-1:0]   sdata;
        logic [REG_AW-1:0] waddr;
        logic              we;
        kind  = allow_mem ? 2'(rand_bits(2)) : 2'b00; // 1x is memory and 11 a store
        width = 2'(rand_bits(2));
        op_c  = rand_bits(XLEN);
        sdata = rand_bits(XLEN);
        waddr = REG_AW'(rand_bits(REG_AW));
        we    = 1'(rand_bits(1));
        if (kind[1]) begin
            op_c = op_c & 32'h0000_00ff; // low 64 words for more address reuse
        end
        issue_op(kind[1], kind[0], width, op_c, sdata, waddr, we);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            tick();
            waited++;
            assert (waited < DRAIN_TIMEOUT) else abort_run("results never came out");
        end
        repeat (4) tick(); // room for a duplicate to show up
    endtask

    initial begin
        int waited;
        ex_valid      <= 1'b0;
        ex_op_c       <= '0;
        ex_store_data <= '0;
        ex_reg_waddr  <= '0;
        ex_reg_we     <= 1'b0;
        ex_mtype      <= 1'b0;
        ex_mem_rw     <= 1'b0;
        ex_mem_width  <= WIDTH_WORD;
        ext_stall     <= 1'b0;
        flush         <= 1'b0;
        lfsr_q = SEED;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            assert (waited < RESET_TIMEOUT) else abort_run("reset never released");
        end while (!rst_n);

        test_name = "alu_pass";
        check_alu_lat = 1'b1;
        for (int i = 0; i < 8; i++) begin
            issue_random(1'b0);
        end
        wait_drain();
        check_alu_lat = 1'b0;

        test_name = "store_load_word";
        issue_op(1'b1, 1'b1, WIDTH_WORD, 32'h0000_0040, 32'hdead_beef, 5'd0, 1'b0);
        issue_op(1'b1, 1'b0, WIDTH_WORD, 32'h0000_0040, 32'h0, 5'd3, 1'b1);
        wait_drain();

        test_name = "byte_half_sext";
        issue_op(1'b1, 1'b1, WIDTH_WORD, 32'h0000_0080, 32'h1122_3344, 5'd0, 1'b0);
        issue_op(1'b1, 1'b1, WIDTH_BYTE, 32'h0000_0080, 32'haaaa_aaf0, 5'd0, 1'b0);
        issue_op(1'b1, 1'b0, WIDTH_BYTE, 32'h0000_0080, 32'h0, 5'd4, 1'b1);
        issue_op(1'b1, 1'b0, WIDTH_HALF, 32'h0000_0080, 32'h0, 5'd5, 1'b1);
        issue_op(1'b1, 1'b1, WIDTH_HALF, 32'h0000_0084, 32'h5555_8001, 5'd0, 1'b0);
        issue_op(1'b1, 1'b0, WIDTH_HALF, 32'h0000_0084, 32'h0, 5'd6, 1'b1);
        issue_op(1'b1, 1'b0, WIDTH_WORD, 32'h0000_0080, 32'h0, 5'd7, 1'b1);
        issue_op(1'b1, 1'b0, 2'b00, 32'h0000_0080, 32'h0, 5'd8, 1'b1);
        wait_drain();

        test_name = "stall_on_load";
        issue_op(1'b1, 1'b1, WIDTH_WORD, 32'h0000_00c0, 32'h8765_4321, 5'd0, 1'b0);
        issue_op(1'b1, 1'b0, WIDTH_WORD, 32'h0000_00c0, 32'h0, 5'd9, 1'b1);
        ext_stall <= 1'b1; // spans the data valid pulse
        repeat (6) tick();
        ext_stall <= 1'b0;
        issue_op(1'b0, 1'b0, WIDTH_WORD, 32'h1234_5678, 32'h0, 5'd10, 1'b1);
        wait_drain();

        test_name = "flush_alu";
        issue_op(1'b0, 1'b0, WIDTH_WORD, 32'h1111_1111, 32'h0, 5'd1, 1'b1);
        issue_op(1'b0, 1'b0, WIDTH_WORD, 32'h2222_2222, 32'h0, 5'd2, 1'b1);
        flush <= 1'b1;
        tick();
        flush <= 1'b0;
        issue_op(1'b0, 1'b0, WIDTH_WORD, 32'h3333_3333, 32'h0, 5'd3, 1'b1);
        wait_drain();

        test_name = "random_mix";
        stall_rand = 1'b1;
        for (int n = 0; n < N_RANDOM; n++) begin
            issue_random(1'b1);
            if (rand_bits(2) == 32'd0) begin
                tick(); // idle gap
            end
        end
        stall_rand = 1'b0;
        ext_stall <= 1'b0;
        wait_drain();

        if (fail_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/tb_clkgen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen #(
    parameter int HALF_PERIOD  = 5, // 10 ns clock
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

/* rtl/mem_subsys_top.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_subsys_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       ex_valid_i,
    input  logic [mem_pkg::XLEN-1:0]   ex_op_c_i,
    input  logic [mem_pkg::XLEN-1:0]   ex_store_data_i,
    input  logic [mem_pkg::REG_AW-1:0] ex_reg_waddr_i,
    input  logic                       ex_reg_we_i,
    input  logic                       ex_mtype_i,
    input  logic                       ex_mem_rw_i,
    input  logic [1:0]                 ex_mem_width_i,
    input  logic                       ext_stall_i,
    input  logic                       flush_i,
    output logic                       stall_o,
    output logic                       wb_valid_o,
    output logic [mem_pkg::XLEN-1:0]   wb_data_o,
    output logic [mem_pkg::REG_AW-1:0] wb_reg_waddr_o,
    output logic                       wb_reg_we_o
);
    import mem_pkg::*;

    exmem_t          ex_payload;
    exmem_t          exmem_q;
    logic            exmem_valid;
    memwb_t          mem_payload;
    memwb_t          memwb_q;
    logic            memwb_in_valid;

    logic            dmem_req;
    logic            dmem_data_valid;
    logic [XLEN-1:0] dmem_rdata;
    logic            busy;
    logic            hold_exmem;
    logic            hold_memwb;
    logic            flush_exmem;
    logic [XLEN-1:0] mem_result;

    assign ex_payload.op_c       = ex_op_c_i;
    assign ex_payload.store_data = ex_store_data_i;
    assign ex_payload.reg_waddr  = ex_reg_waddr_i;
    assign ex_payload.reg_we     = ex_reg_we_i;
    assign ex_payload.mtype      = ex_mtype_i;
    assign ex_payload.mem_rw     = ex_mem_rw_i;
    assign ex_payload.mem_width  = ex_mem_width_i;

    pipe_reg #(.payload_t(exmem_t)) u_exmem_reg (
        .clk     (clk),
        .rst_n   (rst_n),
        .hold_i  (hold_exmem),
        .flush_i (flush_exmem),
        .valid_i (ex_valid_i),
        .data_i  (ex_payload),
        .valid_o (exmem_valid),
        .data_o  (exmem_q)
    );

    flow_ctrl u_flow_ctrl (
        .clk               (clk),
        .rst_n             (rst_n),
        .exmem_valid_i     (exmem_valid),
        .exmem_mtype_i     (exmem_q.mtype),
        .ext_stall_i       (ext_stall_i),
        .flush_i           (flush_i),
        .dmem_data_valid_i (dmem_data_valid),
        .dmem_req_o        (dmem_req),
        .busy_o            (busy),
        .hold_exmem_o      (hold_exmem),
        .hold_memwb_o      (hold_memwb),
        .flush_exmem_o     (flush_exmem),
        .stall_o           (stall_o)
    );

    dmem u_dmem (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_i        (dmem_req),
        .rw_i         (exmem_q.mem_rw),
        .width_i      (exmem_q.mem_width),
        .addr_i       (exmem_q.op_c),
        .wdata_i      (exmem_q.store_data),
        .data_valid_o (dmem_data_valid),
        .rdata_o      (dmem_rdata)
    );

    mem_stage u_mem_stage (
        .clk               (clk),
        .rst_n             (rst_n),
        .exmem_op_c_i      (exmem_q.op_c),
        .exmem_mtype_i     (exmem_q.mtype),
        .exmem_mem_rw_i    (exmem_q.mem_rw),
        .exmem_mem_width_i (exmem_q.mem_width),
        .dmem_rdata_i      (dmem_rdata),
        .dmem_data_valid_i (dmem_data_valid),
        .hold_i            (hold_exmem),
        .flush_i           (flush_exmem),
        .mem_op_c_o        (mem_result)
    );

    // bubble while the access is in flight or the op is flushed
    assign memwb_in_valid = exmem_valid & ~busy & ~flush_exmem;

    assign mem_payload.wb_data   = mem_result;
    assign mem_payload.reg_waddr = exmem_q.reg_waddr;
    assign mem_payload.reg_we    = exmem_q.reg_we;

    pipe_reg #(.payload_t(memwb_t)) u_memwb_reg (
        .clk     (clk),
        .rst_n   (rst_n),
        .hold_i  (hold_memwb),
        .flush_i (1'b0),
        .valid_i (memwb_in_valid),
        .data_i  (mem_payload),
        .valid_o (wb_valid_o),
        .data_o  (memwb_q)
    );

    assign wb_data_o      = memwb_q.wb_data;
    assign wb_reg_waddr_o = memwb_q.reg_waddr;
    assign wb_reg_we_o    = memwb_q.reg_we & wb_valid_o; // no write from a bubble

endmodule

`default_nettype wire

/* rtl/mem_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [mem_pkg::XLEN-1:0] exmem_op_c_i,
    input  logic                     exmem_mtype_i,
    input  logic                     exmem_mem_rw_i,
    input  logic [1:0]               exmem_mem_width_i,
    input  logic [mem_pkg::XLEN-1:0] dmem_rdata_i,
    input  logic                     dmem_data_valid_i,
    input  logic                     hold_i,
    input  logic                     flush_i,
    output logic [mem_pkg::XLEN-1:0] mem_op_c_o
);
    import mem_pkg::*;

    logic [XLEN-1:0] load_buf_q;
    logic            buf_full_q;
    logic [XLEN-1:0] load_word;
    logic            is_load;

    // data valid while held, keep it until the hold lets go
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_full_q <= 1'b0;
        end else if (hold_i && dmem_data_valid_i) begin
            buf_full_q <= 1'b1;
        end else if (!hold_i || flush_i) begin
            buf_full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (hold_i && dmem_data_valid_i) begin
            load_buf_q <= dmem_rdata_i;
        end
    end

    assign is_load = exmem_mtype_i & ~exmem_mem_rw_i;

    always_comb begin
        if (dmem_data_valid_i) begin
            load_word = dmem_rdata_i;    // live
        end else if (buf_full_q) begin
            load_word = load_buf_q;      // buffered under hold
        end else begin
            load_word = '0;
        end
    end

    always_comb begin
        if (is_load) begin
            case (exmem_mem_width_i)
                WIDTH_BYTE: mem_op_c_o = {{(XLEN-8){load_word[7]}}, load_word[7:0]};
                WIDTH_HALF: mem_op_c_o = {{(XLEN-16){load_word[15]}}, load_word[15:0]};
                WIDTH_WORD: mem_op_c_o = load_word;
                default:    mem_op_c_o = '0;
            endcase
        end else begin
            mem_op_c_o = exmem_op_c_i; // alu value, or address on a store
        end
    end

endmodule

`default_nettype wire

/* rtl/flow_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module flow_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic exmem_valid_i,
    input  logic exmem_mtype_i,
    input  logic ext_stall_i,
    input  logic flush_i,
    input  logic dmem_data_valid_i,
    output logic dmem_req_o,
    output logic busy_o,
    output logic hold_exmem_o,
    output logic hold_memwb_o,
    output logic flush_exmem_o,
    output logic stall_o
);

    typedef enum logic {
        ST_IDLE,
        ST_WAIT
    } state_t;

    state_t state_q;
    logic   issued_q; // op in ex/mem already sent to dmem

    assign dmem_req_o = (state_q == ST_IDLE) && exmem_valid_i && exmem_mtype_i && !issued_q;

    // busy drops in the data valid cycle
    assign busy_o = dmem_req_o || ((state_q == ST_WAIT) && !dmem_data_valid_i);

    assign hold_exmem_o  = busy_o | ext_stall_i;
    assign stall_o       = busy_o | ext_stall_i;
    assign hold_memwb_o  = ext_stall_i;
    assign flush_exmem_o = flush_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: if (dmem_req_o) state_q <= ST_WAIT;
                ST_WAIT: if (dmem_data_valid_i) state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // keeps a held op from being requested twice
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issued_q <= 1'b0;
        end else if (!hold_exmem_o) begin
            issued_q <= 1'b0; // ex/mem takes a new slot
        end else if (dmem_req_o) begin
            issued_q <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* rtl/dmem.sv */
`timescale 1ns/10ps
`default_nettype none

module dmem (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req_i,
    input  logic                     rw_i,
    input  logic [1:0]               width_i,
    input  logic [mem_pkg::XLEN-1:0] addr_i,
    input  logic [mem_pkg::XLEN-1:0] wdata_i,
    output logic                     data_valid_o,
    output logic [mem_pkg::XLEN-1:0] rdata_o
);
    import mem_pkg::*;

    logic [XLEN-1:0]    mem_q [DMEM_DEPTH];
    logic [DMEM_LAT-1:0] req_pipe_q;
    logic [DMEM_LAT:0]   req_line;
    logic                fire;

    // request fields latched at req_i
    logic                acc_rw_q;
    logic [1:0]          acc_width_q;
    logic [DMEM_AW-1:0]  acc_idx_q;
    logic [XLEN-1:0]     acc_wdata_q;

    logic                cur_rw;
    logic [1:0]          cur_width;
    logic [DMEM_AW-1:0]  cur_idx;
    logic [XLEN-1:0]     cur_wdata;
    logic [XBYTES-1:0]   byte_en;

    assign req_line     = {req_pipe_q, req_i};
    assign fire         = req_line[DMEM_LAT-1]; // edge that raises data_valid_o
    assign data_valid_o = req_pipe_q[DMEM_LAT-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_pipe_q <= '0;
        end else begin
            req_pipe_q <= req_line[DMEM_LAT-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (req_i) begin
            acc_rw_q    <= rw_i;
            acc_width_q <= width_i;
            acc_idx_q   <= addr_i[DMEM_AW+1:2];
            acc_wdata_q <= wdata_i;
        end
    end

    // live fields only matter when the latency is a single cycle
    assign cur_rw    = req_i ? rw_i : acc_rw_q;
    assign cur_width = req_i ? width_i : acc_width_q;
    assign cur_idx   = req_i ? addr_i[DMEM_AW+1:2] : acc_idx_q;
    assign cur_wdata = req_i ? wdata_i : acc_wdata_q;

    // low lanes only
    always_comb begin
        byte_en = '0;
        case (cur_width)
            WIDTH_BYTE: byte_en[0]   = 1'b1;
            WIDTH_HALF: byte_en[1:0] = 2'b11;
            WIDTH_WORD: byte_en      = '1;
            default:    byte_en      = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                mem_q[i] <= '0;
            end
        end else if (fire && cur_rw) begin
            for (int b = 0; b < XBYTES; b++) begin
                if (byte_en[b]) begin
                    mem_q[cur_idx][8*b +: 8] <= cur_wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire && !cur_rw) begin
            rdata_o <= mem_q[cur_idx];
        end
    end

endmodule

`default_nettype wire

/* rtl/pipe_reg.sv */
`timescale 1ns/10ps
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     hold_i,
    input  logic     flush_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    // hold wins over flush
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
        end else if (!hold_i) begin
            valid_o <= valid_i & ~flush_i;
        end
    end

    // payload left alone on flush, only the valid bit drops
    always_ff @(posedge clk) begin
        if (!hold_i && !flush_i) begin
            data_o <= data_i;
        end
    end

endmodule

`default_nettype wire

/* rtl/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    localparam int XLEN       = 32;
    localparam int XBYTES     = XLEN / 8;
    localparam int REG_AW     = 5;
    localparam int DMEM_DEPTH = 256;
    localparam int DMEM_AW    = $clog2(DMEM_DEPTH); // word index, addr[9:2]
    localparam int DMEM_LAT   = 2;                  // req to data valid, in cycles

    // access width codes, 2'b00 is invalid
    localparam logic [1:0] WIDTH_BYTE = 2'b01;
    localparam logic [1:0] WIDTH_HALF = 2'b10;
    localparam logic [1:0] WIDTH_WORD = 2'b11;

    typedef struct packed {
        logic [XLEN-1:0]   op_c;       // alu result or address
        logic [XLEN-1:0]   store_data;
        logic [REG_AW-1:0] reg_waddr;
        logic              reg_we;
        logic              mtype;      // memory op
        logic              mem_rw;     // 1 = store
        logic [1:0]        mem_width;
    } exmem_t;

    typedef struct packed {
        logic [XLEN-1:0]   wb_data;
        logic [REG_AW-1:0] reg_waddr;
        logic              reg_we;
    } memwb_t;

endpackage

`default_nettype wire
